//--- hw/bank_cfg.svh
// Scratchpad configuration: widths, depths and counts shared by every block.
`ifndef BANK_CFG_SVH
`define BANK_CFG_SVH

// Number of banks a wide access is split over.
// Must divide the wide data width into whole bytes.
`define BANK_NUM_BANKS 4

// Width of one wide access, a power of two.
`define BANK_DATA_WIDTH 64

// Byte address width.
`define BANK_ADDR_WIDTH 16

// Words held by each bank, so 512 bytes of wide address space.
`define BANK_WORDS 64

// Depth of every per-bank request and response FIFO.
`define BANK_FIFO_DEPTH 2

// Outstanding wide accesses per port.
// The dead-write FIFO holds one more than this.
`define BANK_MAX_TRANS 2

// Number of requesters sharing the banks.
`define BANK_NUM_PORTS 2

`endif

//--- hw/bank_pkg.sv
// Scratchpad types for addresses, wide and per-bank data, and bank request/response payloads.
`default_nettype none

`include "bank_cfg.svh"

package bank_pkg;

  // Byte address.
  typedef logic [`BANK_ADDR_WIDTH-1:0] addr_t;

  // Wide access data and its byte strobe.
  typedef logic [`BANK_DATA_WIDTH-1:0]   wide_data_t;
  typedef logic [`BANK_DATA_WIDTH/8-1:0] wide_strb_t;

  // One bank's slice of the wide word.
  typedef logic [`BANK_DATA_WIDTH/`BANK_NUM_BANKS-1:0]   bank_data_t;
  typedef logic [`BANK_DATA_WIDTH/`BANK_NUM_BANKS/8-1:0] bank_strb_t;

  // Payload of a per-bank request FIFO.
  typedef struct packed {
    addr_t      addr;
    bank_data_t wdata;
    bank_strb_t strb;
    logic       we;
  } bank_req_t;

  // Payload of a per-bank response FIFO.
  typedef struct packed {
    bank_data_t rdata;
    logic       err;
  } bank_rsp_t;

endpackage

`default_nettype wire

//--- hw/stream_fifo.sv
// Fall-through valid/ready FIFO, a circular buffer whose payload type is a parameter.
`default_nettype none

`include "bank_cfg.svh"

module stream_fifo #(
  parameter type         t     = logic [7:0],
  parameter int unsigned depth = `BANK_FIFO_DEPTH
) (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  input  wire logic valid_i,
  output logic      ready_o,
  input  wire t     data_i,
  output logic      valid_o,
  input  wire logic ready_i,
  output t          data_o
);

  // A depth of one still needs a one-bit pointer.
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  t                 mem_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             empty;
  logic             full;
  logic             push;
  logic             pop;

  // Pointer advance with wrap at the last entry.
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = (count_q == '0);
  assign full  = (count_q == cnt_w'(depth));

  // Room is reported while not full.
  assign ready_o = !full;

  // Empty buffer passes the input straight through.
  assign valid_o = !empty || valid_i;
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];

  // Nothing is stored when the input is consumed in the same cycle.
  assign pop  = ready_i && !empty;
  assign push = valid_i && !full && !(empty && ready_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + cnt_w'(push) - cnt_w'(pop);
    end
  end

  // Storage.
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // No entry is offered while the buffer is full.
  assert property (@(posedge clk_i) disable iff (!arst_n_i) valid_i |-> !full);

endmodule

`default_nettype wire

//--- hw/mem_to_banks.sv
// Bank splitter: cuts a wide req/gnt access into bank accesses and merges the responses.
`default_nettype none

`include "bank_cfg.svh"

module mem_to_banks #(
  parameter bit hide_strb = 1'b1
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  arst_n_i,
  input  wire logic                                  req_i,
  output logic                                       gnt_o,
  input  wire bank_pkg::addr_t                       addr_i,
  input  wire bank_pkg::wide_data_t                  wdata_i,
  input  wire bank_pkg::wide_strb_t                  strb_i,
  input  wire logic                                  we_i,
  output logic                                       rvalid_o,
  output bank_pkg::wide_data_t                       rdata_o,
  output logic [`BANK_NUM_BANKS-1:0]                 ersp_o,
  output logic [`BANK_NUM_BANKS-1:0]                 bank_req_o,
  input  wire logic [`BANK_NUM_BANKS-1:0]            bank_gnt_i,
  output bank_pkg::addr_t [`BANK_NUM_BANKS-1:0]      bank_addr_o,
  output bank_pkg::bank_data_t [`BANK_NUM_BANKS-1:0] bank_wdata_o,
  output bank_pkg::bank_strb_t [`BANK_NUM_BANKS-1:0] bank_strb_o,
  output logic [`BANK_NUM_BANKS-1:0]                 bank_we_o,
  input  wire logic [`BANK_NUM_BANKS-1:0]            bank_rvalid_i,
  input  wire bank_pkg::bank_data_t [`BANK_NUM_BANKS-1:0] bank_rdata_i,
  input  wire logic [`BANK_NUM_BANKS-1:0]            bank_err_i
);

  localparam int unsigned nb         = `BANK_NUM_BANKS;
  localparam int unsigned bank_bits  = $bits(bank_pkg::bank_data_t);
  localparam int unsigned bank_bytes = $bits(bank_pkg::bank_strb_t);
  localparam int unsigned off_bits   = $clog2($bits(bank_pkg::wide_strb_t));

  bank_pkg::bank_req_t [nb-1:0] req_in;
  bank_pkg::bank_req_t [nb-1:0] req_head;
  bank_pkg::bank_rsp_t [nb-1:0] rsp_in;
  bank_pkg::bank_rsp_t [nb-1:0] rsp_head;
  bank_pkg::addr_t              base_addr;
  logic                         req_push;
  logic [nb-1:0]                req_ready;
  logic [nb-1:0]                head_valid;
  logic [nb-1:0]                head_pop;
  logic [nb-1:0]                rsp_ready;
  logic [nb-1:0]                rsp_valid;
  logic [nb-1:0]                dead_mark;
  logic                         dead_full;

  // Wide word base address, low byte offset dropped.
  assign base_addr = (addr_i >> off_bits) << off_bits;

  // The wide access needs room in every FIFO at once.
  assign gnt_o    = (&req_ready) && (&rsp_ready) && !dead_full;
  assign req_push = req_i && gnt_o;

  for (genvar i = 0; i < nb; i++) begin : gen_bank
    // Each bank sees its own byte offset and slice.
    assign req_in[i].addr  = base_addr + bank_pkg::addr_t'(i * bank_bytes);
    assign req_in[i].wdata = wdata_i[i*bank_bits +: bank_bits];
    assign req_in[i].strb  = strb_i[i*bank_bytes +: bank_bytes];
    assign req_in[i].we    = we_i;

    stream_fifo #(
      .t     (bank_pkg::bank_req_t),
      .depth (`BANK_FIFO_DEPTH)
    ) i_req_fifo (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .valid_i  (req_push),
      .ready_o  (req_ready[i]),
      .data_i   (req_in[i]),
      .valid_o  (head_valid[i]),
      .ready_i  (head_pop[i]),
      .data_o   (req_head[i])
    );

    assign bank_addr_o[i]  = req_head[i].addr;
    assign bank_wdata_o[i] = req_head[i].wdata;
    assign bank_strb_o[i]  = req_head[i].strb;
    assign bank_we_o[i]    = req_head[i].we;

    if (hide_strb) begin : gen_hide
      logic head_dead;
      // Zero-strobe write never reaches the bank, it is drained locally.
      assign head_dead     = req_head[i].we && (req_head[i].strb == '0);
      assign bank_req_o[i] = head_valid[i] && !head_dead;
      assign head_pop[i]   = head_dead || bank_gnt_i[i];
    end else begin : gen_pass
      assign bank_req_o[i] = head_valid[i];
      assign head_pop[i]   = bank_gnt_i[i];
    end

    assign rsp_in[i].rdata = bank_rdata_i[i];
    assign rsp_in[i].err   = bank_err_i[i];

    stream_fifo #(
      .t     (bank_pkg::bank_rsp_t),
      .depth (`BANK_FIFO_DEPTH)
    ) i_rsp_fifo (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .valid_i  (bank_rvalid_i[i]),
      .ready_o  (rsp_ready[i]),
      .data_i   (rsp_in[i]),
      .valid_o  (rsp_valid[i]),
      .ready_i  (rvalid_o && !dead_mark[i]),
      .data_o   (rsp_head[i])
    );

    // Dead banks answer with zero data and no error.
    assign rdata_o[i*bank_bits +: bank_bits] = dead_mark[i] ? '0 : rsp_head[i].rdata;
    assign ersp_o[i] = !dead_mark[i] && rsp_head[i].err;
  end

  if (hide_strb) begin : gen_dead_fifo
    logic [nb-1:0] dead_in;
    logic [nb-1:0] dead_out;
    logic          dead_ready;
    logic          dead_valid;

    // One mask per wide access, one bit per bank with no bytes to write.
    for (genvar i = 0; i < nb; i++) begin : gen_dead_in
      assign dead_in[i] = we_i && (req_in[i].strb == '0);
    end

    stream_fifo #(
      .t     (logic [nb-1:0]),
      .depth (`BANK_MAX_TRANS + 1)
    ) i_dead_fifo (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .valid_i  (req_push),
      .ready_o  (dead_ready),
      .data_i   (dead_in),
      .valid_o  (dead_valid),
      .ready_i  (rvalid_o),
      .data_o   (dead_out)
    );

    assign dead_full = !dead_ready;
    assign dead_mark = dead_valid ? dead_out : '0;

    // Every wide response has its access record at the head.
    assert property (@(posedge clk_i) disable iff (!arst_n_i) rvalid_o |-> dead_valid);
  end else begin : gen_no_dead_fifo
    assign dead_full = 1'b0;
    assign dead_mark = '0;
  end

  // Wide response once every bank has answered or is dead.
  assign rvalid_o = &(rsp_valid | dead_mark);

endmodule

`default_nettype wire

//--- hw/bank_arbiter.sv
// Round-robin arbiter sharing one bank between two splitters and steering its responses.
`default_nettype none

`include "bank_cfg.svh"

module bank_arbiter (
  input  wire logic                                         clk_i,
  input  wire logic                                         arst_n_i,
  input  wire logic [`BANK_NUM_PORTS-1:0]                   req_i,
  output logic [`BANK_NUM_PORTS-1:0]                        gnt_o,
  output logic [`BANK_NUM_PORTS-1:0]                        rvalid_o,
  input  wire bank_pkg::addr_t [`BANK_NUM_PORTS-1:0]        addr_i,
  input  wire bank_pkg::bank_data_t [`BANK_NUM_PORTS-1:0]   wdata_i,
  input  wire bank_pkg::bank_strb_t [`BANK_NUM_PORTS-1:0]   strb_i,
  input  wire logic [`BANK_NUM_PORTS-1:0]                   we_i,
  output bank_pkg::bank_data_t                              rdata_o,
  output logic                                              err_o,
  output logic                                              en_o,
  output logic                                              we_o,
  output bank_pkg::addr_t                                   addr_o,
  output bank_pkg::bank_data_t                              wdata_o,
  output bank_pkg::bank_strb_t                              strb_o,
  input  wire logic                                         rvalid_i,
  input  wire bank_pkg::bank_data_t                         rdata_i,
  input  wire logic                                         err_i
);

  // Port favoured when both request.
  logic prio_q;
  // Port served this cycle, and the one served last cycle.
  logic sel;
  logic sel_q;

  // Port 1 wins if alone, or if it holds the priority.
  assign sel = req_i[1] && (!req_i[0] || prio_q);

  // Combinational grant in the request cycle.
  assign gnt_o[0] = req_i[0] && !sel;
  assign gnt_o[1] = req_i[1] && sel;

  // Bank is enabled whenever anyone asks, the bank never stalls.
  assign en_o    = |req_i;
  assign we_o    = we_i[sel];
  assign addr_o  = addr_i[sel];
  assign wdata_o = wdata_i[sel];
  assign strb_o  = strb_i[sel];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q   <= 1'b0;
      sel_q    <= 1'b0;
      rvalid_o <= '0;
    end else begin
      if (en_o) begin
        // Next time favour the port not served now.
        prio_q <= !sel;
        sel_q  <= sel;
      end
      // Response goes to the port that issued the access.
      rvalid_o[0] <= rvalid_i && !sel_q;
      rvalid_o[1] <= rvalid_i && sel_q;
    end
  end

  // Response payload, shared by both ports.
  always_ff @(posedge clk_i) begin
    rdata_o <= rdata_i;
    err_o   <= err_i;
  end

  // A port refused while asking wins the following cycle if it still asks.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_i[0] && !gnt_o[0]) |=> (!req_i[0] || gnt_o[0]));
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_i[1] && !gnt_o[1]) |=> (!req_i[1] || gnt_o[1]));

  // The bank answers each enable exactly one cycle later.
  assert property (@(posedge clk_i) disable iff (!arst_n_i) en_o |=> rvalid_i);
  assert property (@(posedge clk_i) disable iff (!arst_n_i) !en_o |=> !rvalid_i);

endmodule

`default_nettype wire

//--- hw/sram_bank.sv
// Single-port byte-strobed bank memory, one cycle read latency, with out-of-range error.
`default_nettype none

`include "bank_cfg.svh"

module sram_bank (
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  input  wire logic                 en_i,
  input  wire logic                 we_i,
  input  wire bank_pkg::addr_t      addr_i,
  input  wire bank_pkg::bank_data_t wdata_i,
  input  wire bank_pkg::bank_strb_t strb_i,
  output logic                      rvalid_o,
  output bank_pkg::bank_data_t      rdata_o,
  output logic                      err_o
);

  // Word index is the address in wide words.
  localparam int unsigned off_bits  = $clog2(`BANK_DATA_WIDTH / 8);
  localparam int unsigned idx_bits  = $clog2(`BANK_WORDS);
  localparam int unsigned num_bytes = $bits(bank_pkg::bank_strb_t);

  bank_pkg::bank_data_t mem_q [`BANK_WORDS];
  bank_pkg::addr_t      word_idx;
  logic                 in_range;

  assign word_idx = addr_i >> off_bits;
  assign in_range = (word_idx < bank_pkg::addr_t'(`BANK_WORDS));

  // Every enable answers one cycle later.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= en_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      // Out of range reads as zero with the error bit set.
      rdata_o <= in_range ? mem_q[word_idx[idx_bits-1:0]] : '0;
      err_o   <= !in_range;
      // Only strobed bytes change, and never out of range.
      if (we_i && in_range) begin
        for (int b = 0; b < num_bytes; b++) begin
          if (strb_i[b]) begin
            mem_q[word_idx[idx_bits-1:0]][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/banked_mem_top.sv
// Banked scratchpad top: two splitters sharing four banks through round-robin arbiters.
`default_nettype none

`include "bank_cfg.svh"

module banked_mem_top (
  input  wire logic                                          clk_i,
  input  wire logic                                          arst_n_i,
  input  wire logic [`BANK_NUM_PORTS-1:0]                    req_i,
  output wire logic [`BANK_NUM_PORTS-1:0]                    gnt_o,
  input  wire logic [`BANK_NUM_PORTS-1:0]                    we_i,
  output wire logic [`BANK_NUM_PORTS-1:0]                    rvalid_o,
  input  wire bank_pkg::addr_t [`BANK_NUM_PORTS-1:0]         addr_i,
  input  wire bank_pkg::wide_data_t [`BANK_NUM_PORTS-1:0]    wdata_i,
  input  wire bank_pkg::wide_strb_t [`BANK_NUM_PORTS-1:0]    strb_i,
  output wire bank_pkg::wide_data_t [`BANK_NUM_PORTS-1:0]    rdata_o,
  output wire logic [`BANK_NUM_PORTS-1:0][`BANK_NUM_BANKS-1:0] ersp_o
);

  localparam int unsigned np = `BANK_NUM_PORTS;
  localparam int unsigned nb = `BANK_NUM_BANKS;

  // Splitter side, indexed port then bank.
  wire logic [np-1:0][nb-1:0]                 sp_req;
  wire logic [np-1:0][nb-1:0]                 sp_gnt;
  wire logic [np-1:0][nb-1:0]                 sp_we;
  wire logic [np-1:0][nb-1:0]                 sp_rvalid;
  wire bank_pkg::addr_t [np-1:0][nb-1:0]      sp_addr;
  wire bank_pkg::bank_data_t [np-1:0][nb-1:0] sp_wdata;
  wire bank_pkg::bank_strb_t [np-1:0][nb-1:0] sp_strb;

  // Arbiter side, indexed bank then port.
  wire logic [nb-1:0][np-1:0]                 ab_req;
  wire logic [nb-1:0][np-1:0]                 ab_gnt;
  wire logic [nb-1:0][np-1:0]                 ab_we;
  wire logic [nb-1:0][np-1:0]                 ab_rvalid;
  wire bank_pkg::addr_t [nb-1:0][np-1:0]      ab_addr;
  wire bank_pkg::bank_data_t [nb-1:0][np-1:0] ab_wdata;
  wire bank_pkg::bank_strb_t [nb-1:0][np-1:0] ab_strb;
  // Response data is broadcast, rvalid picks the port.
  wire bank_pkg::bank_data_t [nb-1:0]         ab_rdata;
  wire logic [nb-1:0]                         ab_err;

  // Arbiter to memory.
  wire logic [nb-1:0]                 m_en;
  wire logic [nb-1:0]                 m_we;
  wire logic [nb-1:0]                 m_rvalid;
  wire logic [nb-1:0]                 m_err;
  wire bank_pkg::addr_t [nb-1:0]      m_addr;
  wire bank_pkg::bank_data_t [nb-1:0] m_wdata;
  wire bank_pkg::bank_strb_t [nb-1:0] m_strb;
  wire bank_pkg::bank_data_t [nb-1:0] m_rdata;

  for (genvar p = 0; p < np; p++) begin : gen_port
    mem_to_banks #(
      .hide_strb (1'b1)
    ) i_split (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .req_i         (req_i[p]),
      .gnt_o         (gnt_o[p]),
      .addr_i        (addr_i[p]),
      .wdata_i       (wdata_i[p]),
      .strb_i        (strb_i[p]),
      .we_i          (we_i[p]),
      .rvalid_o      (rvalid_o[p]),
      .rdata_o       (rdata_o[p]),
      .ersp_o        (ersp_o[p]),
      .bank_req_o    (sp_req[p]),
      .bank_gnt_i    (sp_gnt[p]),
      .bank_addr_o   (sp_addr[p]),
      .bank_wdata_o  (sp_wdata[p]),
      .bank_strb_o   (sp_strb[p]),
      .bank_we_o     (sp_we[p]),
      .bank_rvalid_i (sp_rvalid[p]),
      .bank_rdata_i  (ab_rdata),
      .bank_err_i    (ab_err)
    );
  end

  for (genvar b = 0; b < nb; b++) begin : gen_bank
    // Regroup the splitter wires per bank.
    for (genvar p = 0; p < np; p++) begin : gen_xpose
      assign ab_req[b][p]    = sp_req[p][b];
      assign ab_we[b][p]     = sp_we[p][b];
      assign ab_addr[b][p]   = sp_addr[p][b];
      assign ab_wdata[b][p]  = sp_wdata[p][b];
      assign ab_strb[b][p]   = sp_strb[p][b];
      assign sp_gnt[p][b]    = ab_gnt[b][p];
      assign sp_rvalid[p][b] = ab_rvalid[b][p];
    end

    bank_arbiter i_arb (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .req_i    (ab_req[b]),
      .gnt_o    (ab_gnt[b]),
      .rvalid_o (ab_rvalid[b]),
      .addr_i   (ab_addr[b]),
      .wdata_i  (ab_wdata[b]),
      .strb_i   (ab_strb[b]),
      .we_i     (ab_we[b]),
      .rdata_o  (ab_rdata[b]),
      .err_o    (ab_err[b]),
      .en_o     (m_en[b]),
      .we_o     (m_we[b]),
      .addr_o   (m_addr[b]),
      .wdata_o  (m_wdata[b]),
      .strb_o   (m_strb[b]),
      .rvalid_i (m_rvalid[b]),
      .rdata_i  (m_rdata[b]),
      .err_i    (m_err[b])
    );

    sram_bank i_sram (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .en_i     (m_en[b]),
      .we_i     (m_we[b]),
      .addr_i   (m_addr[b]),
      .wdata_i  (m_wdata[b]),
      .strb_i   (m_strb[b]),
      .rvalid_o (m_rvalid[b]),
      .rdata_o  (m_rdata[b]),
      .err_o    (m_err[b])
    );
  end

endmodule

`default_nettype wire

//--- bench/banked_mem_tb.sv
// Banked scratchpad testbench: random two-port traffic checked against a byte memory model.
`default_nettype none

`include "bank_cfg.svh"

module banked_mem_tb;

  localparam int NP          = `BANK_NUM_PORTS;
  localparam int NB          = `BANK_NUM_BANKS;
  localparam int DW          = `BANK_DATA_WIDTH;
  localparam int SW          = `BANK_DATA_WIDTH / 8;
  localparam int WORDS       = `BANK_WORDS;
  localparam int HALF        = `BANK_WORDS / 2;
  localparam int NUM_TXNS    = 300;
  localparam int TIMEOUT_CYC = 20 * NP * NUM_TXNS;
  // How read data is compared at the response.
  localparam int CMP_ALWAYS    = 0;
  localparam int CMP_IF_STABLE = 1;
  localparam int CMP_NONE      = 2;

  typedef struct {
    logic [DW-1:0] data;
    logic [NB-1:0] err;
    int            mode;
    int            word;
    int            ver;
    int            pend_word;
  } exp_t;

  logic                      clk_i;
  logic                      arst_n_i;
  logic [NP-1:0]             req_i;
  logic [NP-1:0]             we_i;
  logic [NP-1:0][15:0]       addr_i;
  logic [NP-1:0][DW-1:0]     wdata_i;
  logic [NP-1:0][SW-1:0]     strb_i;
  wire logic [NP-1:0]        gnt_o;
  wire logic [NP-1:0]        rvalid_o;
  wire logic [NP-1:0][DW-1:0] rdata_o;
  wire logic [NP-1:0][NB-1:0] ersp_o;

  // Byte model of the whole valid range.
  logic [7:0] mem_model [WORDS*SW];
  // Per word: writes granted so far, and writes still in flight.
  int         wr_ver [WORDS];
  int         pend [WORDS];
  exp_t       exp_q [NP][$];
  integer     seed;
  int         issued [NP];
  int         resp_cnt [NP];
  int         last_word [NP];
  logic       busy [NP];
  logic       taken [NP];
  int         value_errs;
  int         other_errs;
  int         cycles;

  banked_mem_top DUT (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .gnt_o    (gnt_o),
    .we_i     (we_i),
    .rvalid_o (rvalid_o),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .strb_i   (strb_i),
    .rdata_o  (rdata_o),
    .ersp_o   (ersp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Picks the next access of a port, or an idle cycle.
  task automatic next_request(input int p);
    int         sel;
    int         word;
    logic [3:0] keep;
    sel = $random(seed) & 7;
    if (issued[p] >= HALF && sel == 7) begin
      req_i[p] = 1'b0;
    end else begin
      if (issued[p] < HALF) begin
        // Fill the own half with full words first.
        word       = p * HALF + issued[p];
        we_i[p]    = 1'b1;
        strb_i[p]  = '1;
      end else if ($random(seed) & 1) begin
        // Writes stay inside the own half, apart from a few beyond the range.
        if (($random(seed) & 15) == 0) begin
          word = WORDS + ($random(seed) & (WORDS - 1));
        end else begin
          word = p * HALF + ($random(seed) & (HALF - 1));
        end
        last_word[p] = word;
        we_i[p]      = 1'b1;
        keep         = $random(seed);
        case ($random(seed) & 3)
          0:       strb_i[p] = '1;
          1:       strb_i[p] = '0;
          2:       strb_i[p] = $random(seed);
          default: strb_i[p] = SW'($random(seed)) & {{2{keep[3]}}, {2{keep[2]}},
                                                      {2{keep[1]}}, {2{keep[0]}}};
        endcase
      end else begin
        we_i[p]   = 1'b0;
        strb_i[p] = $random(seed);
        case ($random(seed) & 7)
          0, 1:    word = last_word[p];
          2:       word = WORDS + ($random(seed) & 15);
          3:       word = $random(seed) & 16'h1fff;
          default: word = $random(seed) & (WORDS - 1);
        endcase
      end
      // Low address bits are random, the splitter aligns them away.
      addr_i[p]  = {word[12:0], 3'($random(seed))};
      wdata_i[p] = {$random(seed), $random(seed)};
      req_i[p]   = 1'b1;
      busy[p]    = 1'b1;
      issued[p]++;
    end
  endtask

  // Builds the expected response of a granted access and updates the model.
  task automatic record_grant(input int p);
    exp_t       e;
    int         w;
    logic       in_range;
    logic       dead;
    w        = addr_i[p][15:3];
    in_range = (w < WORDS);
    e.word      = in_range ? w : 0;
    e.ver       = 0;
    e.pend_word = -1;
    for (int b = 0; b < NB; b++) begin
      // A write with no strobe in a bank leaves that bank silent.
      dead       = we_i[p] && (strb_i[p][2*b +: 2] == 2'b00);
      e.err[b]   = !in_range && !dead;
      e.data[16*b +: 16] = (in_range && !dead) ?
                           {mem_model[w*SW + 2*b + 1], mem_model[w*SW + 2*b]} : 16'h0000;
    end
    if (we_i[p]) begin
      e.mode = CMP_NONE;
    end else if (!in_range || (w / HALF) == p) begin
      e.mode = CMP_ALWAYS;
    end else if (pend[w] == 0) begin
      // Other half is exact only if no owner write overlaps the read.
      e.mode = CMP_IF_STABLE;
      e.ver  = wr_ver[w];
    end else begin
      e.mode = CMP_NONE;
    end
    if (we_i[p] && in_range) begin
      for (int k = 0; k < SW; k++) begin
        if (strb_i[p][k]) begin
          mem_model[w*SW + k] = wdata_i[p][8*k +: 8];
        end
      end
      wr_ver[w]++;
      pend[w]++;
      e.pend_word = w;
    end
    exp_q[p].push_back(e);
    taken[p] = 1'b1;
  endtask

  // Compares one wide response with the oldest expected entry.
  task automatic check_response(input int p);
    exp_t e;
    if (rvalid_o[p] === 1'b1) begin
      if (exp_q[p].size() == 0) begin
        other_errs++;
        $display("t=%0t port %0d returned a response with no request outstanding", $time, p);
      end else begin
        e = exp_q[p].pop_front();
        resp_cnt[p]++;
        if (ersp_o[p] !== e.err) begin
          value_errs++;
          $display("CHECK FAILED t=%0t port %0d ersp_o expected %b got %b",
                   $time, p, e.err, ersp_o[p]);
        end
        if (e.mode == CMP_ALWAYS || (e.mode == CMP_IF_STABLE && wr_ver[e.word] == e.ver)) begin
          if (rdata_o[p] !== e.data) begin
            value_errs++;
            $display("CHECK FAILED t=%0t port %0d rdata_o expected %h got %h",
                     $time, p, e.data, rdata_o[p]);
          end
        end
        if (e.pend_word >= 0) begin
          pend[e.pend_word]--;
        end
      end
    end else if (rvalid_o[p] !== 1'b0) begin
      other_errs++;
      $display("t=%0t port %0d rvalid_o is unknown", $time, p);
    end
  endtask

  // Sample at the falling edge, grants before responses.
  // A write with no strobe anywhere may answer in its own grant cycle.
  always @(negedge clk_i) begin
    if (!arst_n_i) begin
      if (rvalid_o !== '0) begin
        other_errs++;
        $display("t=%0t rvalid_o is not low during reset", $time);
      end
    end else begin
      for (int p = 0; p < NP; p++) begin
        if (req_i[p] === 1'b1 && gnt_o[p] === 1'b1) begin
          record_grant(p);
        end
      end
      for (int p = 0; p < NP; p++) begin
        check_response(p);
      end
    end
  end

  // Run limit.
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYC) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, responses seen %0d and %0d of %0d per port",
             cycles, resp_cnt[0], resp_cnt[1], NUM_TXNS);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    seed       = 32'ha003;
    value_errs = 0;
    other_errs = 0;
    arst_n_i   = 1'b0;
    req_i      = '0;
    we_i       = '0;
    addr_i     = '0;
    wdata_i    = '0;
    strb_i     = '0;
    for (int p = 0; p < NP; p++) begin
      issued[p]    = 0;
      resp_cnt[p]  = 0;
      last_word[p] = p * HALF;
      busy[p]      = 1'b0;
      taken[p]     = 1'b0;
    end
    for (int w = 0; w < WORDS; w++) begin
      wr_ver[w] = 0;
      pend[w]   = 0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    for (int p = 0; p < NP; p++) begin
      next_request(p);
    end
    // Empty FIFOs accept the first requests at once.
    @(negedge clk_i);
    if (gnt_o !== '1) begin
      other_errs++;
      $display("t=%0t first requests were not granted at once", $time);
    end
    while (busy[0] || busy[1] || issued[0] < NUM_TXNS || issued[1] < NUM_TXNS) begin
      @(posedge clk_i);
      #1;
      for (int p = 0; p < NP; p++) begin
        if (taken[p]) begin
          taken[p] = 1'b0;
          busy[p]  = 1'b0;
          req_i[p] = 1'b0;
        end
        if (!busy[p] && issued[p] < NUM_TXNS) begin
          next_request(p);
        end
      end
    end
    while (resp_cnt[0] < NUM_TXNS || resp_cnt[1] < NUM_TXNS) begin
      @(posedge clk_i);
    end
    // A few quiet cycles catch stray responses.
    repeat (5) @(posedge clk_i);
    $display("Error counts: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/bank_pkg.sv
hw/stream_fifo.sv
hw/mem_to_banks.sv
hw/bank_arbiter.sv
hw/sram_bank.sv
hw/banked_mem_top.sv
bench/banked_mem_tb.sv
